/* all.f */
design/vga_pkg.sv
design/vga_timing.sv
design/draw_bg.sv
design/draw_buttons.sv
design/draw_rect.sv
design/draw_rect_ctl.sv
design/top_vga.sv
tb/top_vga_tb.sv

/* design/draw_bg.sv */
`default_nettype none

module draw_bg
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int V_ACTIVE = vga_pkg::V_ACTIVE
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [POS_W-1:0]   hcount_in,
    input  logic [POS_W-1:0]   vcount_in,
    input  logic               hsync_in,
    input  logic               vsync_in,
    input  logic               hblnk_in,
    input  logic               vblnk_in,
    output logic [POS_W-1:0]   hcount_out,
    output logic [POS_W-1:0]   vcount_out,
    output logic               hsync_out,
    output logic               vsync_out,
    output logic               hblnk_out,
    output logic               vblnk_out,
    output logic [COLOR_W-1:0] rgb_out
);

    logic               on_border;
    logic [COLOR_W-1:0] rgb_nxt;

    // First or last active row or column
    assign on_border = (hcount_in == '0) || (hcount_in == POS_W'(H_ACTIVE - 1)) ||
                       (vcount_in == '0) || (vcount_in == POS_W'(V_ACTIVE - 1));

    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = '0;
        end else if (on_border) begin
            rgb_nxt = BORDER_COLOR;
        end else begin
            rgb_nxt = BG_COLOR;
        end
    end

    // One stage delay on every field
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/draw_buttons.sv */
`default_nettype none

module draw_buttons
    import vga_pkg::*;
#(
    parameter int BTN_L_X = 100,
    parameter int BTN_R_X = 600,
    parameter int BTN_Y   = 300,
    parameter int BTN_W   = 100,
    parameter int BTN_H   = 75
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [POS_W-1:0]   hcount_in,
    input  logic [POS_W-1:0]   vcount_in,
    input  logic               hsync_in,
    input  logic               vsync_in,
    input  logic               hblnk_in,
    input  logic               vblnk_in,
    input  logic [COLOR_W-1:0] rgb_in,
    input  logic [POS_W-1:0]   xpos,
    input  logic [POS_W-1:0]   ypos,
    output logic [POS_W-1:0]   hcount_out,
    output logic [POS_W-1:0]   vcount_out,
    output logic               hsync_out,
    output logic               vsync_out,
    output logic               hblnk_out,
    output logic               vblnk_out,
    output logic [COLOR_W-1:0] rgb_out,
    output logic               button_pressed
);

    logic               in_btn_row;
    logic               in_button;
    logic               rect_on_row;
    logic               touch;
    logic [COLOR_W-1:0] rgb_nxt;

    // Both buttons share one row band
    assign in_btn_row = in_span(int'(vcount_in), BTN_Y, BTN_H);
    assign in_button  = in_btn_row &&
                        (in_span(int'(hcount_in), BTN_L_X, BTN_W) ||
                         in_span(int'(hcount_in), BTN_R_X, BTN_W));

    // Rectangle box against each button box
    assign rect_on_row = spans_overlap(int'(ypos), RECT_H, BTN_Y, BTN_H);
    assign touch       = rect_on_row &&
                         (spans_overlap(int'(xpos), RECT_W, BTN_L_X, BTN_W) ||
                          spans_overlap(int'(xpos), RECT_W, BTN_R_X, BTN_W));

    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = '0;
        end else if (in_button) begin
            rgb_nxt = BUTTON_COLOR;
        end else begin
            rgb_nxt = rgb_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount_out     <= '0;
            vcount_out     <= '0;
            hsync_out      <= 1'b0;
            vsync_out      <= 1'b0;
            hblnk_out      <= 1'b0;
            vblnk_out      <= 1'b0;
            rgb_out        <= '0;
            button_pressed <= 1'b0;
        end else begin
            hcount_out     <= hcount_in;
            vcount_out     <= vcount_in;
            hsync_out      <= hsync_in;
            vsync_out      <= vsync_in;
            hblnk_out      <= hblnk_in;
            vblnk_out      <= vblnk_in;
            rgb_out        <= rgb_nxt;
            // Level, follows the position every cycle
            button_pressed <= touch;
        end
    end

endmodule

`default_nettype wire

/* design/draw_rect.sv */
`default_nettype none

module draw_rect
    import vga_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [POS_W-1:0]   hcount_in,
    input  logic [POS_W-1:0]   vcount_in,
    input  logic               hsync_in,
    input  logic               vsync_in,
    input  logic               hblnk_in,
    input  logic               vblnk_in,
    input  logic [COLOR_W-1:0] rgb_in,
    input  logic [POS_W-1:0]   xpos,
    input  logic [POS_W-1:0]   ypos,
    output logic [POS_W-1:0]   hcount_out,
    output logic [POS_W-1:0]   vcount_out,
    output logic               hsync_out,
    output logic               vsync_out,
    output logic               hblnk_out,
    output logic               vblnk_out,
    output logic [COLOR_W-1:0] rgb_out
);

    logic               in_rect;
    logic [COLOR_W-1:0] rgb_nxt;

    // Top left corner at xpos, ypos
    assign in_rect = in_span(int'(hcount_in), int'(xpos), RECT_W) &&
                     in_span(int'(vcount_in), int'(ypos), RECT_H);

    // Rectangle sits on top of everything drawn earlier
    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = '0;
        end else if (in_rect) begin
            rgb_nxt = RECT_COLOR;
        end else begin
            rgb_nxt = rgb_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/draw_rect_ctl.sv */
`default_nettype none

module draw_rect_ctl
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int HOME_X   = 396,
    parameter int HOME_Y   = 300
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             v_tick,
    input  logic             move_left,
    input  logic             move_right,
    input  logic             button_pressed,
    output logic [POS_W-1:0] xpos,
    output logic [POS_W-1:0] ypos
);

    // Rightmost legal left edge
    localparam int X_MAX = H_ACTIVE - RECT_W;

    rect_ctl_state_t  state;
    rect_ctl_state_t  state_nxt;
    logic             v_tick_d;
    logic             frame_start;
    logic [POS_W-1:0] xpos_nxt;
    int               x_cur;
    int               x_new;

    // No vertical movement, rectangle stays on the home row
    assign ypos = POS_W'(HOME_Y);

    // Rising edge of vsync, once per frame
    assign frame_start = v_tick && !v_tick_d;

    always_comb begin
        state_nxt = state;
        xpos_nxt  = xpos;
        x_cur     = int'(xpos);
        x_new     = x_cur;
        case (state)
            ST_WAIT_FRAME: begin
                if (frame_start) begin
                    // Touching a button wins over any move request
                    state_nxt = button_pressed ? ST_HOME : ST_UPDATE;
                end
            end
            ST_UPDATE: begin
                // Both or neither pressed means stay put
                if (move_left && !move_right) begin
                    x_new = x_cur - RECT_STEP;
                end else if (move_right && !move_left) begin
                    x_new = x_cur + RECT_STEP;
                end
                // Keep the whole rectangle on screen
                if (x_new < 0) begin
                    x_new = 0;
                end else if (x_new > X_MAX) begin
                    x_new = X_MAX;
                end
                xpos_nxt  = POS_W'(x_new);
                state_nxt = ST_WAIT_FRAME;
            end
            ST_HOME: begin
                xpos_nxt  = POS_W'(HOME_X);
                state_nxt = ST_WAIT_FRAME;
            end
            default: begin
                state_nxt = ST_WAIT_FRAME;
            end
        endcase
    end

    // Position lands two cycles after the vsync edge, inside vertical blanking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_WAIT_FRAME;
            v_tick_d <= 1'b0;
            xpos     <= POS_W'(HOME_X);
        end else begin
            state    <= state_nxt;
            v_tick_d <= v_tick;
            xpos     <= xpos_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/top_vga.sv */
`default_nettype none

module top_vga
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::H_FRONT,
    parameter int H_SYNC   = vga_pkg::H_SYNC,
    parameter int H_BACK   = vga_pkg::H_BACK,
    parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::V_FRONT,
    parameter int V_SYNC   = vga_pkg::V_SYNC,
    parameter int V_BACK   = vga_pkg::V_BACK,
    // Buttons an eighth of the screen in from each side, home in the middle
    parameter int BTN_W    = H_ACTIVE / 8,
    parameter int BTN_H    = V_ACTIVE / 8,
    parameter int BTN_L_X  = H_ACTIVE / 8,
    parameter int BTN_R_X  = H_ACTIVE - H_ACTIVE / 4,
    parameter int BTN_Y    = V_ACTIVE / 2,
    parameter int HOME_X   = (H_ACTIVE - RECT_W) / 2,
    parameter int HOME_Y   = BTN_Y
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       move_left,
    input  logic       move_right,
    output logic       vs,
    output logic       hs,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    // Stage buses, timing to bg to buttons to rect
    logic [POS_W-1:0]   tim_hcount, bg_hcount, btn_hcount;
    logic [POS_W-1:0]   tim_vcount, bg_vcount, btn_vcount;
    logic               tim_hsync, bg_hsync, btn_hsync, rect_hsync;
    logic               tim_vsync, bg_vsync, btn_vsync, rect_vsync;
    logic               tim_hblnk, bg_hblnk, btn_hblnk;
    logic               tim_vblnk, bg_vblnk, btn_vblnk;
    logic [COLOR_W-1:0] bg_rgb, btn_rgb, rect_rgb;

    logic [POS_W-1:0] xpos;
    logic [POS_W-1:0] ypos;
    logic             button_pressed;

    // Sync and color both from the last stage so they stay aligned
    assign vs        = rect_vsync;
    assign hs        = rect_hsync;
    assign {r, g, b} = rect_rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (
        .clk, .rst_n,
        .hcount(tim_hcount), .vcount(tim_vcount),
        .hsync(tim_hsync), .vsync(tim_vsync),
        .hblnk(tim_hblnk), .vblnk(tim_vblnk)
    );

    draw_bg #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_draw_bg (
        .clk, .rst_n,
        .hcount_in(tim_hcount), .vcount_in(tim_vcount),
        .hsync_in(tim_hsync), .vsync_in(tim_vsync),
        .hblnk_in(tim_hblnk), .vblnk_in(tim_vblnk),
        .hcount_out(bg_hcount), .vcount_out(bg_vcount),
        .hsync_out(bg_hsync), .vsync_out(bg_vsync),
        .hblnk_out(bg_hblnk), .vblnk_out(bg_vblnk),
        .rgb_out(bg_rgb)
    );

    draw_buttons #(
        .BTN_L_X(BTN_L_X), .BTN_R_X(BTN_R_X), .BTN_Y(BTN_Y), .BTN_W(BTN_W), .BTN_H(BTN_H)
    ) u_draw_buttons (
        .clk, .rst_n,
        .hcount_in(bg_hcount), .vcount_in(bg_vcount),
        .hsync_in(bg_hsync), .vsync_in(bg_vsync),
        .hblnk_in(bg_hblnk), .vblnk_in(bg_vblnk),
        .rgb_in(bg_rgb), .xpos, .ypos,
        .hcount_out(btn_hcount), .vcount_out(btn_vcount),
        .hsync_out(btn_hsync), .vsync_out(btn_vsync),
        .hblnk_out(btn_hblnk), .vblnk_out(btn_vblnk),
        .rgb_out(btn_rgb), .button_pressed
    );

    // Last stage, only sync and color leave the chip
    draw_rect u_draw_rect (
        .clk, .rst_n,
        .hcount_in(btn_hcount), .vcount_in(btn_vcount),
        .hsync_in(btn_hsync), .vsync_in(btn_vsync),
        .hblnk_in(btn_hblnk), .vblnk_in(btn_vblnk),
        .rgb_in(btn_rgb), .xpos, .ypos,
        .hcount_out(), .vcount_out(),
        .hsync_out(rect_hsync), .vsync_out(rect_vsync),
        .hblnk_out(), .vblnk_out(),
        .rgb_out(rect_rgb)
    );

    // Frame tick taken from the background stage vsync
    draw_rect_ctl #(.H_ACTIVE(H_ACTIVE), .HOME_X(HOME_X), .HOME_Y(HOME_Y)) u_draw_rect_ctl (
        .clk, .rst_n,
        .v_tick(bg_vsync),
        .move_left, .move_right, .button_pressed,
        .xpos, .ypos
    );

endmodule

`default_nettype wire

/* design/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // Default mode, 800x600 at 60 Hz with a 40 MHz pixel clock
    localparam int H_ACTIVE = 800;
    localparam int H_FRONT  = 40;
    localparam int H_SYNC   = 128;
    localparam int H_BACK   = 88;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 600;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 4;
    localparam int V_BACK   = 23;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Counter and position width, covers H_TOTAL
    localparam int POS_W   = 11;
    // 4 bits each of r, g, b
    localparam int COLOR_W = 12;

    localparam logic [COLOR_W-1:0] BG_COLOR     = 12'h136;
    localparam logic [COLOR_W-1:0] BORDER_COLOR = 12'hfff;
    localparam logic [COLOR_W-1:0] BUTTON_COLOR = 12'hf80;
    localparam logic [COLOR_W-1:0] RECT_COLOR   = 12'h0f0;

    // Player rectangle size and speed in pixels per frame
    localparam int RECT_W    = 8;
    localparam int RECT_H    = 8;
    localparam int RECT_STEP = 2;

    typedef enum logic [1:0] {
        ST_WAIT_FRAME = 2'd0,
        ST_UPDATE     = 2'd1,
        ST_HOME       = 2'd2
    } rect_ctl_state_t;

    // True when pos lies in [start, start + len)
    function automatic logic in_span(input int pos, input int start, input int len);
        return (pos >= start) && (pos < start + len);
    endfunction

    // Two half-open spans share at least one pixel
    function automatic logic spans_overlap(input int a_start, input int a_len,
                                           input int b_start, input int b_len);
        return (a_start < b_start + b_len) && (b_start < a_start + a_len);
    endfunction

endpackage

`default_nettype wire

/* design/vga_timing.sv */
`default_nettype none

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::H_FRONT,
    parameter int H_SYNC   = vga_pkg::H_SYNC,
    parameter int H_BACK   = vga_pkg::H_BACK,
    parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::V_FRONT,
    parameter int V_SYNC   = vga_pkg::V_SYNC,
    parameter int V_BACK   = vga_pkg::V_BACK
) (
    input  logic             clk,
    input  logic             rst_n,
    output logic [POS_W-1:0] hcount,
    output logic [POS_W-1:0] vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             hblnk,
    output logic             vblnk
);

    // Last pixel of a line and last line of a frame
    localparam int H_LAST = H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1;
    localparam int V_LAST = V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1;

    // Sync pulses follow the front porch
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic [POS_W-1:0] hcount_nxt;
    logic [POS_W-1:0] vcount_nxt;

    // Next raster position, line advances on horizontal wrap
    always_comb begin
        hcount_nxt = hcount + 1'b1;
        vcount_nxt = vcount;
        if (hcount == POS_W'(H_LAST)) begin
            hcount_nxt = '0;
            if (vcount == POS_W'(V_LAST)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end
    end

    // Windows decoded from the next count so they line up with the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= in_span(int'(hcount_nxt), H_SYNC_START, H_SYNC);
            vsync  <= in_span(int'(vcount_nxt), V_SYNC_START, V_SYNC);
            hblnk  <= (hcount_nxt >= POS_W'(H_ACTIVE));
            vblnk  <= (vcount_nxt >= POS_W'(V_ACTIVE));
        end
    end

endmodule

`default_nettype wire

/* tb/top_vga_tb.sv */
`default_nettype none

module top_vga_tb
    import vga_pkg::*;
();

    // Small video mode, 80 clocks per line and 54 lines per frame
    localparam int H_ACT = 64;
    localparam int H_FP  = 4;
    localparam int H_SW  = 8;
    localparam int H_BP  = 4;
    localparam int H_TOT = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_ACT = 48;
    localparam int V_FP  = 2;
    localparam int V_SW  = 2;
    localparam int V_BP  = 2;
    localparam int V_TOT = V_ACT + V_FP + V_SW + V_BP;

    // One pixel wide buttons on the edge columns of row 20
    // so the rectangle clamps before it touches one
    localparam int BTN_L_X = 0;
    localparam int BTN_R_X = H_ACT - 1;
    localparam int BTN_Y   = 20;
    localparam int BTN_W   = 1;
    localparam int BTN_H   = 6;
    // Odd home column, so the last step toward either edge overshoots
    localparam int HOME_X  = 29;
    localparam int HOME_Y  = BTN_Y;

    localparam int CLK_PERIOD   = 8;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;

    // Pattern sequence: one frame both high, left run, right run, random
    localparam int LEFT_RUN     = 17;
    localparam int RIGHT_RUN    = 16;
    localparam int RANDOM_RUN   = 6;
    localparam int NUM_PATTERNS = 1 + LEFT_RUN + RIGHT_RUN + RANDOM_RUN;
    localparam int WATCHDOG     = (NUM_PATTERNS + 6) * FRAME_CYCLES * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       move_left;
    logic       move_right;
    logic       vs;
    logic       hs;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    // Raster and position model
    int   h = 0;
    int   v = 0;
    bit   locked = 1'b0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    int   hs_period_cnt = 0;
    int   hs_high_cnt = 0;
    int   vs_lines = 0;
    int   vs_high_lines = 0;
    bit   vs_seen = 1'b0;
    int   model_x = HOME_X;
    int   first_col = 'h7ff;
    int   frames_seen = 0;

    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] rand_state = 32'h12e2;

    top_vga #(
        .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP),
        .BTN_W(BTN_W), .BTN_H(BTN_H), .BTN_L_X(BTN_L_X), .BTN_R_X(BTN_R_X),
        .BTN_Y(BTN_Y), .HOME_X(HOME_X), .HOME_Y(HOME_Y)
    ) dut_i (
        .clk, .rst_n, .move_left, .move_right,
        .vs, .hs, .r, .g, .b
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_equal(input string name, input int expected, input int actual);
        check_count++;
        assert (actual == expected) else begin
            error_count++;
            $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Half-open boxes, rectangle against each button
    function automatic bit touches_button(input int x, input int y);
        bit rows;
        rows = (y < BTN_Y + BTN_H) && (BTN_Y < y + RECT_H);
        return rows && (((x < BTN_L_X + BTN_W) && (BTN_L_X < x + RECT_W)) ||
                        ((x < BTN_R_X + BTN_W) && (BTN_R_X < x + RECT_W)));
    endfunction

    // Layer order from top: rectangle, buttons, border, fill
    function automatic int expected_color(input int px, input int py, input int x, input int y);
        if (px >= H_ACT || py >= V_ACT) begin
            return 0;
        end
        if (px >= x && px < x + RECT_W && py >= y && py < y + RECT_H) begin
            return int'(RECT_COLOR);
        end
        if (py >= BTN_Y && py < BTN_Y + BTN_H &&
            ((px >= BTN_L_X && px < BTN_L_X + BTN_W) ||
             (px >= BTN_R_X && px < BTN_R_X + BTN_W))) begin
            return int'(BUTTON_COLOR);
        end
        if (px == 0 || px == H_ACT - 1 || py == 0 || py == V_ACT - 1) begin
            return int'(BORDER_COLOR);
        end
        return int'(BG_COLOR);
    endfunction

    // Controller rule, applied once per frame with the held levels
    // Rectangle never leaves the home row
    task automatic update_position();
        if (touches_button(model_x, HOME_Y)) begin
            model_x = HOME_X;
        end else begin
            if (move_left && !move_right) begin
                model_x = model_x - RECT_STEP;
            end else if (move_right && !move_left) begin
                model_x = model_x + RECT_STEP;
            end
            if (model_x < 0) begin
                model_x = 0;
            end else if (model_x > H_ACT - RECT_W) begin
                model_x = H_ACT - RECT_W;
            end
        end
    endtask

    task automatic apply_pattern(input int idx);
        if (idx == 0) begin
            move_left  <= 1'b1;
            move_right <= 1'b1;
        end else if (idx <= LEFT_RUN) begin
            move_left  <= 1'b1;
            move_right <= 1'b0;
        end else if (idx <= LEFT_RUN + RIGHT_RUN) begin
            move_left  <= 1'b0;
            move_right <= 1'b1;
        end else begin
            rand_state = next_rand(rand_state);
            move_left  <= rand_state[0];
            move_right <= rand_state[1];
        end
    endtask

    // Outputs sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin : monitor
        int rgb;
        rgb = int'({r, g, b});
        if (!rst_n) begin
            check_equal("reset rgb", 0, rgb);
            check_equal("reset hs", 0, int'(hs));
            check_equal("reset vs", 0, int'(vs));
        end else begin
            if (locked) begin
                h = h + 1;
                if (h == H_TOT) begin
                    h = 0;
                    v = (v + 1) % V_TOT;
                end
            end
            hs_period_cnt++;
            if (hs) begin
                hs_high_cnt++;
            end
            if (hs && !hs_prev) begin
                // First hsync after reset belongs to line 0
                if (!locked) begin
                    h = H_ACT + H_FP;
                    v = 0;
                    locked = 1'b1;
                end else begin
                    check_equal("hs period", H_TOT, hs_period_cnt);
                end
                hs_period_cnt = 0;
                vs_lines++;
                if (vs) begin
                    vs_high_lines++;
                end
            end
            if (!hs && hs_prev) begin
                check_equal("hs width", H_SW, hs_high_cnt);
                hs_high_cnt = 0;
            end
            if (locked) begin
                check_equal($sformatf("pixel %0d,%0d", h, v),
                            expected_color(h, v, model_x, HOME_Y), rgb);
                if (h < H_ACT && v < V_ACT && rgb == int'(RECT_COLOR) && h < first_col) begin
                    first_col = h;
                end
            end
            if (vs && !vs_prev) begin
                check_equal("vs start line", V_ACT + V_FP, v);
                check_equal("vs start column", 0, h);
                if (vs_seen) begin
                    check_equal("vs period lines", V_TOT, vs_lines);
                end
                vs_seen  = 1'b1;
                vs_lines = 0;
                // Frame just drawn, then the move for the next one
                check_equal("rect first column", model_x, first_col);
                update_position();
                first_col = 'h7ff;
                frames_seen++;
            end
            if (!vs && vs_prev) begin
                check_equal("vs width lines", V_SW, vs_high_lines);
                vs_high_lines = 0;
            end
        end
        hs_prev = hs;
        vs_prev = vs;
    end

    initial begin
        rst_n      = 1'b0;
        move_left  = 1'b0;
        move_right = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // New levels land well after the controller has sampled the old ones
        for (int i = 0; i < NUM_PATTERNS; i++) begin
            wait (frames_seen == i + 1);
            @(posedge clk);
            apply_pattern(i);
        end
        wait (frames_seen == NUM_PATTERNS + 1);
        @(posedge clk);
        move_left  <= 1'b0;
        move_right <= 1'b0;
        wait (frames_seen == NUM_PATTERNS + 2);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Whole pattern run plus a few frames of slack
    initial begin
        #(WATCHDOG);
        $display("Timeout: frame count stuck at %0d", frames_seen);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
